//--- src/exec_pkg.sv
package exec_pkg;

    typedef logic [63:0] word_t;
    typedef logic [63:0] addr_t;
    typedef logic [31:0] u32;

    localparam logic [6:0] OPC_LUI       = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC     = 7'b0010111;
    localparam logic [6:0] OPC_JAL       = 7'b1101111;
    localparam logic [6:0] OPC_JALR      = 7'b1100111;
    localparam logic [6:0] OPC_BRANCH    = 7'b1100011;
    localparam logic [6:0] OPC_LOAD      = 7'b0000011;
    localparam logic [6:0] OPC_STORE     = 7'b0100011;
    localparam logic [6:0] OPC_OP_IMM    = 7'b0010011;
    localparam logic [6:0] OPC_OP        = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM_32 = 7'b0011011;
    localparam logic [6:0] OPC_OP_32     = 7'b0111011;

    typedef enum logic [5:0] {
        ADD, SUB, SLL, SLT, SLTU, XOR, SRL, SRA, OR, AND,
        ADDI, SLTI, SLTIU, XORI, ORI, ANDI, SLLI, SRLI, SRAI,
        ADDW, SUBW, SLLW, SRLW, SRAW,
        ADDIW, SLLIW, SRLIW, SRAIW,
        LUI, AUIPC,
        JAL, JALR,
        BEQ, BNE, BLT, BGE, BLTU, BGEU,
        LB, LH, LW, LD, LBU, LHU, LWU,
        SB, SH, SW, SD,
        ILLEGAL
    } op_e;

    // Field layouts of the six base instruction formats, msb first.
    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0] imm;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } i_fmt_t;

    typedef struct packed {
        logic [6:0] imm_hi;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] imm_lo;
        logic [6:0] opcode;
    } s_fmt_t;

    typedef struct packed {
        logic       imm_12;
        logic [5:0] imm_10_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm_4_1;
        logic       imm_11;
        logic [6:0] opcode;
    } b_fmt_t;

    typedef struct packed {
        logic [19:0] imm;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } u_fmt_t;

    typedef struct packed {
        logic       imm_20;
        logic [9:0] imm_10_1;
        logic       imm_11;
        logic [7:0] imm_19_12;
        logic [4:0] rd;
        logic [6:0] opcode;
    } j_fmt_t;

    typedef union packed {
        r_fmt_t r_fmt;
        i_fmt_t i_fmt;
        s_fmt_t s_fmt;
        b_fmt_t b_fmt;
        u_fmt_t u_fmt;
        j_fmt_t j_fmt;
    } inst_u;

    typedef enum logic [2:0] {
        RES_REG,
        RES_LOAD,
        RES_STORE,
        RES_BRANCH,
        RES_ILLEGAL
    } res_kind_e;

    typedef struct packed {
        inst_u inst;
        addr_t pc;
        word_t rs1_val;
        word_t rs2_val;
    } exec_in_t;

    typedef struct packed {
        op_e        op;
        addr_t      pc;
        word_t      rs1_val;
        word_t      rs2_val;
        word_t      imm;
        logic [4:0] rd;
    } dec_t;

    typedef struct packed {
        op_e        op;
        addr_t      pc;
        word_t      rs1_val;
        word_t      rs2_val;
        logic [4:0] rd;
        word_t      value;
        addr_t      target;
    } alu_t;

    typedef struct packed {
        res_kind_e  kind;
        logic [4:0] rd;
        word_t      value;
        addr_t      next_pc;
    } exec_res_t;

endpackage

//--- src/inst_decode.sv
module inst_decode
    import exec_pkg::*;
(
    input  logic     clk,
    input  logic     arst_n,
    input  logic     advance,
    input  logic     in_valid,
    input  exec_in_t in,
    output logic     dec_valid,
    output dec_t     dec
);

    inst_u      iw;
    logic [2:0] funct3;
    logic [6:0] funct7;
    word_t      imm_i;
    word_t      imm_s;
    word_t      imm_b;
    word_t      imm_u;
    word_t      imm_j;
    word_t      shamt6;
    word_t      shamt5;
    op_e        op;
    word_t      imm;

    assign iw     = in.inst;
    assign funct3 = iw.r_fmt.funct3;
    assign funct7 = iw.r_fmt.funct7;

    // Sign-extended immediates, one per format.
    assign imm_i  = {{52{iw.i_fmt.imm[11]}}, iw.i_fmt.imm};
    assign imm_s  = {{52{iw.s_fmt.imm_hi[6]}}, iw.s_fmt.imm_hi, iw.s_fmt.imm_lo};
    assign imm_b  = {{51{iw.b_fmt.imm_12}}, iw.b_fmt.imm_12, iw.b_fmt.imm_11,
                     iw.b_fmt.imm_10_5, iw.b_fmt.imm_4_1, 1'b0};
    assign imm_u  = {{32{iw.u_fmt.imm[19]}}, iw.u_fmt.imm, 12'b0};
    assign imm_j  = {{43{iw.j_fmt.imm_20}}, iw.j_fmt.imm_20, iw.j_fmt.imm_19_12,
                     iw.j_fmt.imm_11, iw.j_fmt.imm_10_1, 1'b0};
    assign shamt6 = {58'b0, iw.i_fmt.imm[5:0]};
    assign shamt5 = {59'b0, iw.i_fmt.imm[4:0]};

    always_comb begin
        op  = ILLEGAL;
        imm = '0;
        case (iw.r_fmt.opcode)
            OPC_LUI: begin
                op  = LUI;
                imm = imm_u;
            end
            OPC_AUIPC: begin
                op  = AUIPC;
                imm = imm_u;
            end
            OPC_JAL: begin
                op  = JAL;
                imm = imm_j;
            end
            OPC_JALR: begin
                op  = (funct3 == 3'b000) ? JALR : ILLEGAL;
                imm = imm_i;
            end
            OPC_BRANCH: begin
                imm = imm_b;
                case (funct3)
                    3'b000:  op = BEQ;
                    3'b001:  op = BNE;
                    3'b100:  op = BLT;
                    3'b101:  op = BGE;
                    3'b110:  op = BLTU;
                    3'b111:  op = BGEU;
                    default: op = ILLEGAL;
                endcase
            end
            OPC_LOAD: begin
                imm = imm_i;
                case (funct3)
                    3'b000:  op = LB;
                    3'b001:  op = LH;
                    3'b010:  op = LW;
                    3'b011:  op = LD;
                    3'b100:  op = LBU;
                    3'b101:  op = LHU;
                    3'b110:  op = LWU;
                    default: op = ILLEGAL;
                endcase
            end
            OPC_STORE: begin
                imm = imm_s;
                case (funct3)
                    3'b000:  op = SB;
                    3'b001:  op = SH;
                    3'b010:  op = SW;
                    3'b011:  op = SD;
                    default: op = ILLEGAL;
                endcase
            end
            OPC_OP_IMM: begin
                imm = imm_i;
                case (funct3)
                    3'b000: op = ADDI;
                    3'b010: op = SLTI;
                    3'b011: op = SLTIU;
                    3'b100: op = XORI;
                    3'b110: op = ORI;
                    3'b111: op = ANDI;
                    3'b001: begin
                        // 64-bit shifts take a six-bit amount, so funct6 sits above it.
                        op  = (iw.i_fmt.imm[11:6] == 6'b000000) ? SLLI : ILLEGAL;
                        imm = shamt6;
                    end
                    default: begin
                        imm = shamt6;
                        if (iw.i_fmt.imm[11:6] == 6'b000000) begin
                            op = SRLI;
                        end else if (iw.i_fmt.imm[11:6] == 6'b010000) begin
                            op = SRAI;
                        end
                    end
                endcase
            end
            OPC_OP: begin
                case ({funct7, funct3})
                    10'b0000000_000: op = ADD;
                    10'b0100000_000: op = SUB;
                    10'b0000000_001: op = SLL;
                    10'b0000000_010: op = SLT;
                    10'b0000000_011: op = SLTU;
                    10'b0000000_100: op = XOR;
                    10'b0000000_101: op = SRL;
                    10'b0100000_101: op = SRA;
                    10'b0000000_110: op = OR;
                    10'b0000000_111: op = AND;
                    default:         op = ILLEGAL;
                endcase
            end
            OPC_OP_IMM_32: begin
                if (funct3 == 3'b000) begin
                    op  = ADDIW;
                    imm = imm_i;
                end else begin
                    imm = shamt5;
                    case ({funct7, funct3})
                        10'b0000000_001: op = SLLIW;
                        10'b0000000_101: op = SRLIW;
                        10'b0100000_101: op = SRAIW;
                        default:         op = ILLEGAL;
                    endcase
                end
            end
            OPC_OP_32: begin
                case ({funct7, funct3})
                    10'b0000000_000: op = ADDW;
                    10'b0100000_000: op = SUBW;
                    10'b0000000_001: op = SLLW;
                    10'b0000000_101: op = SRLW;
                    10'b0100000_101: op = SRAW;
                    default:         op = ILLEGAL;
                endcase
            end
            default: op = ILLEGAL;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            dec_valid <= 1'b0;
        end else if (advance) begin
            dec_valid <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (advance && in_valid) begin
            dec.op      <= op;
            dec.pc      <= in.pc;
            dec.rs1_val <= in.rs1_val;
            dec.rs2_val <= in.rs2_val;
            dec.imm     <= imm;
            dec.rd      <= iw.r_fmt.rd;
        end
    end

endmodule

//--- src/alu.sv
module alu
    import exec_pkg::*;
(
    input  logic clk,
    input  logic arst_n,
    input  logic advance,
    input  logic dec_valid,
    input  dec_t dec,
    output logic alu_valid,
    output alu_t alu
);

    word_t rs1;
    word_t rs2;
    word_t imm;
    word_t value;
    addr_t target;

    // The W forms produce 32 bits that are sign-extended into the register.
    function automatic word_t sext_w(input u32 x);
        return {{32{x[31]}}, x};
    endfunction

    assign rs1 = dec.rs1_val;
    assign rs2 = dec.rs2_val;
    assign imm = dec.imm;

    always_comb begin
        value  = '0;
        target = '0;
        case (dec.op)
            ADD:   value = rs1 + rs2;
            SUB:   value = rs1 - rs2;
            AND:   value = rs1 & rs2;
            OR:    value = rs1 | rs2;
            XOR:   value = rs1 ^ rs2;
            ADDI:  value = rs1 + imm;
            ANDI:  value = rs1 & imm;
            ORI:   value = rs1 | imm;
            XORI:  value = rs1 ^ imm;
            SLL:   value = rs1 << rs2[5:0];
            SRL:   value = rs1 >> rs2[5:0];
            SRA:   value = $signed(rs1) >>> rs2[5:0];
            SLLI:  value = rs1 << imm[5:0];
            SRLI:  value = rs1 >> imm[5:0];
            SRAI:  value = $signed(rs1) >>> imm[5:0];
            SLT:   value = {63'b0, $signed(rs1) < $signed(rs2)};
            SLTI:  value = {63'b0, $signed(rs1) < $signed(imm)};
            SLTU:  value = {63'b0, rs1 < rs2};
            SLTIU: value = {63'b0, rs1 < imm};
            ADDW:  value = sext_w(rs1[31:0] + rs2[31:0]);
            SUBW:  value = sext_w(rs1[31:0] - rs2[31:0]);
            ADDIW: value = sext_w(rs1[31:0] + imm[31:0]);
            SLLW:  value = sext_w(rs1[31:0] << rs2[4:0]);
            SRLW:  value = sext_w(rs1[31:0] >> rs2[4:0]);
            SRAW:  value = sext_w($signed(rs1[31:0]) >>> rs2[4:0]);
            SLLIW: value = sext_w(rs1[31:0] << imm[4:0]);
            SRLIW: value = sext_w(rs1[31:0] >> imm[4:0]);
            SRAIW: value = sext_w($signed(rs1[31:0]) >>> imm[4:0]);
            LUI:   value = imm;
            AUIPC: value = dec.pc + imm;
            LB, LH, LW, LD, LBU, LHU, LWU, SB, SH, SW, SD: begin
                value = rs1 + imm;
            end
            JAL: begin
                value  = dec.pc + 64'd4;
                target = dec.pc + imm;
            end
            JALR: begin
                value  = dec.pc + 64'd4;
                target = (rs1 + imm) & ~64'd1;
            end
            BEQ, BNE, BLT, BGE, BLTU, BGEU: target = dec.pc + imm;
            default: begin
                value  = '0;
                target = '0;
            end
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            alu_valid <= 1'b0;
        end else if (advance) begin
            alu_valid <= dec_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (advance && dec_valid) begin
            alu.op      <= dec.op;
            alu.pc      <= dec.pc;
            alu.rs1_val <= rs1;
            alu.rs2_val <= rs2;
            alu.rd      <= dec.rd;
            alu.value   <= value;
            alu.target  <= target;
        end
    end

endmodule

//--- src/exec_commit.sv
module exec_commit
    import exec_pkg::*;
(
    input  logic      clk,
    input  logic      arst_n,
    input  logic      advance,
    input  logic      alu_valid,
    input  alu_t      alu,
    output logic      out_valid,
    output exec_res_t out
);

    logic      taken;
    res_kind_e kind;
    addr_t     next_pc;
    logic [4:0] rd;

    always_comb begin
        taken = 1'b0;
        case (alu.op)
            BEQ:      taken = (alu.rs1_val == alu.rs2_val);
            BNE:      taken = (alu.rs1_val != alu.rs2_val);
            BLT:      taken = ($signed(alu.rs1_val) < $signed(alu.rs2_val));
            BGE:      taken = ($signed(alu.rs1_val) >= $signed(alu.rs2_val));
            BLTU:     taken = (alu.rs1_val < alu.rs2_val);
            BGEU:     taken = (alu.rs1_val >= alu.rs2_val);
            JAL, JALR: taken = 1'b1;
            default:  taken = 1'b0;
        endcase
    end

    assign next_pc = taken ? alu.target : alu.pc + 64'd4;

    always_comb begin
        case (alu.op)
            LB, LH, LW, LD, LBU, LHU, LWU:  kind = RES_LOAD;
            SB, SH, SW, SD:                 kind = RES_STORE;
            BEQ, BNE, BLT, BGE, BLTU, BGEU: kind = RES_BRANCH;
            ILLEGAL:                        kind = RES_ILLEGAL;
            default:                        kind = RES_REG;
        endcase
    end

    // Only register-writing results and loads name a destination.
    assign rd = (kind == RES_REG || kind == RES_LOAD) ? alu.rd : 5'd0;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            out_valid <= 1'b0;
        end else if (advance) begin
            out_valid <= alu_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (advance && alu_valid) begin
            out.kind    <= kind;
            out.rd      <= rd;
            out.value   <= alu.value;
            out.next_pc <= next_pc;
        end
    end

endmodule

//--- src/exec_pipe.sv
module exec_pipe
    import exec_pkg::*;
(
    input  logic      clk,
    input  logic      arst_n,
    input  logic      in_valid,
    output logic      in_ready,
    input  exec_in_t  in,
    output logic      out_valid,
    input  logic      out_ready,
    output exec_res_t out
);

    logic advance;
    logic dec_valid;
    dec_t dec;
    logic alu_valid;
    alu_t alu_q;

    // All stages move together, so a stalled output freezes the whole pipe.
    assign advance  = !out_valid || out_ready;
    assign in_ready = advance;

    inst_decode u_decode (
        .clk       (clk),
        .arst_n    (arst_n),
        .advance   (advance),
        .in_valid  (in_valid),
        .in        (in),
        .dec_valid (dec_valid),
        .dec       (dec)
    );

    alu u_alu (
        .clk       (clk),
        .arst_n    (arst_n),
        .advance   (advance),
        .dec_valid (dec_valid),
        .dec       (dec),
        .alu_valid (alu_valid),
        .alu       (alu_q)
    );

    exec_commit u_commit (
        .clk       (clk),
        .arst_n    (arst_n),
        .advance   (advance),
        .alu_valid (alu_valid),
        .alu       (alu_q),
        .out_valid (out_valid),
        .out       (out)
    );

endmodule

//--- test/tb_vectors.svh
task automatic fill_table();
    // Each row gives the instruction, pc, rs1 and rs2, then the expected kind,
    // value, next_pc and rd.
    add_row(32'h0020_82b3, 64'h1000, 64'hffff_ffff_ffff_fff0, 64'h4,
            RES_REG, 64'hffff_ffff_ffff_fff4, 64'h1004, 5'd5);
    add_row(32'h4020_82b3, 64'h1000, 64'hffff_ffff_ffff_fff0, 64'h4,
            RES_REG, 64'hffff_ffff_ffff_ffec, 64'h1004, 5'd5);
    // Same operands, signed and unsigned compares disagree.
    add_row(32'h0020_a2b3, 64'h1000, 64'hffff_ffff_ffff_fff0, 64'h4,
            RES_REG, 64'h1, 64'h1004, 5'd5);
    add_row(32'h0020_b2b3, 64'h1000, 64'hffff_ffff_ffff_fff0, 64'h4,
            RES_REG, 64'h0, 64'h1004, 5'd5);
    add_row(32'h4020_d2b3, 64'h1000, 64'hffff_ffff_ffff_fff0, 64'h4,
            RES_REG, 64'hffff_ffff_ffff_ffff, 64'h1004, 5'd5);
    add_row(32'h0020_c2b3, 64'h1000, 64'h0f0f_0000_ffff_1234, 64'h00ff_00ff_0f0f_f0f0,
            RES_REG, 64'h0ff0_00ff_f0f0_e2c4, 64'h1004, 5'd5);
    add_row(32'hfff0_8293, 64'h1000, 64'h10, 64'h0,
            RES_REG, 64'hf, 64'h1004, 5'd5);
    add_row(32'h0240_9293, 64'h1000, 64'h3, 64'h0,
            RES_REG, 64'h0000_0030_0000_0000, 64'h1004, 5'd5);
    add_row(32'h4040_d293, 64'h1000, 64'h8000_0000_0000_0000, 64'h0,
            RES_REG, 64'hf800_0000_0000_0000, 64'h1004, 5'd5);
    // MUL encoding, not part of the base set.
    add_row(32'h0220_82b3, 64'h1000, 64'h7, 64'h9,
            RES_ILLEGAL, 64'h0, 64'h1004, 5'd0);
    add_row(32'h0020_82bb, 64'h1000, 64'h1234_5678_7fff_ffff, 64'h1,
            RES_REG, 64'hffff_ffff_8000_0000, 64'h1004, 5'd5);
    add_row(32'h4020_d2bb, 64'h1000, 64'h0000_0000_8000_0000, 64'h24,
            RES_REG, 64'hffff_ffff_f800_0000, 64'h1004, 5'd5);
    add_row(32'h8000_02b7, 64'h1000, 64'h0, 64'h0,
            RES_REG, 64'hffff_ffff_8000_0000, 64'h1004, 5'd5);
    add_row(32'h0000_1297, 64'h1000, 64'h0, 64'h0,
            RES_REG, 64'h2000, 64'h1004, 5'd5);
    add_row(32'h0080_b283, 64'h1000, 64'h8000_0000, 64'h0,
            RES_LOAD, 64'h8000_0008, 64'h1004, 5'd5);
    add_row(32'hfe20_ae23, 64'h1000, 64'h100, 64'h55,
            RES_STORE, 64'hfc, 64'h1004, 5'd0);
    add_row(32'h1000_00ef, 64'h1000, 64'h0, 64'h0,
            RES_REG, 64'h1004, 64'h1100, 5'd1);
    add_row(32'h0030_82e7, 64'h1000, 64'h2000, 64'h0,
            RES_REG, 64'h1004, 64'h2002, 5'd5);
    // Branches at pc 2000 with an offset of 16, taken first.
    add_row(32'h0020_8863, 64'h2000, 64'h5, 64'h5,
            RES_BRANCH, 64'h0, 64'h2010, 5'd0);
    add_row(32'h0020_8863, 64'h2000, 64'h5, 64'h6,
            RES_BRANCH, 64'h0, 64'h2004, 5'd0);
    add_row(32'h0020_9863, 64'h2000, 64'h5, 64'h6,
            RES_BRANCH, 64'h0, 64'h2010, 5'd0);
    add_row(32'h0020_9863, 64'h2000, 64'h5, 64'h5,
            RES_BRANCH, 64'h0, 64'h2004, 5'd0);
    add_row(32'h0020_c863, 64'h2000, 64'hffff_ffff_ffff_ffff, 64'h1,
            RES_BRANCH, 64'h0, 64'h2010, 5'd0);
    add_row(32'h0020_c863, 64'h2000, 64'h1, 64'hffff_ffff_ffff_ffff,
            RES_BRANCH, 64'h0, 64'h2004, 5'd0);
    add_row(32'h0020_d863, 64'h2000, 64'h1, 64'hffff_ffff_ffff_ffff,
            RES_BRANCH, 64'h0, 64'h2010, 5'd0);
    add_row(32'h0020_d863, 64'h2000, 64'hffff_ffff_ffff_ffff, 64'h1,
            RES_BRANCH, 64'h0, 64'h2004, 5'd0);
    add_row(32'h0020_e863, 64'h2000, 64'h1, 64'hffff_ffff_ffff_ffff,
            RES_BRANCH, 64'h0, 64'h2010, 5'd0);
    add_row(32'h0020_e863, 64'h2000, 64'hffff_ffff_ffff_ffff, 64'h1,
            RES_BRANCH, 64'h0, 64'h2004, 5'd0);
    add_row(32'h0020_f863, 64'h2000, 64'hffff_ffff_ffff_ffff, 64'h1,
            RES_BRANCH, 64'h0, 64'h2010, 5'd0);
    add_row(32'h0020_f863, 64'h2000, 64'h1, 64'hffff_ffff_ffff_ffff,
            RES_BRANCH, 64'h0, 64'h2004, 5'd0);
endtask

//--- test/tb_exec_pipe.sv
module tb_exec_pipe
    import exec_pkg::*;
();

    localparam int WAIT_LIMIT = 200;

    typedef struct packed {
        exec_in_t  stim;
        exec_res_t exp;
    } vec_t;

    logic      clk;
    logic      arst_n;
    logic      in_valid;
    logic      in_ready;
    exec_in_t  in_data;
    logic      out_valid;
    logic      out_ready;
    exec_res_t out_data;

    vec_t   rows[$];
    int     exp_q[$];
    int     errors = 0;
    int     checked = 0;
    int     cur;
    int     errs_before;
    logic   timed_out = 1'b0;
    logic   random_ready = 1'b0;
    integer seed = 32'h3d1e_dc55;

    exec_pipe dut (
        .clk       (clk),
        .arst_n    (arst_n),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .in        (in_data),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out       (out_data)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    function automatic void add_row(input u32 inst, input addr_t pc, input word_t rs1,
                                     input word_t rs2, input res_kind_e kind,
                                     input word_t value, input addr_t next_pc,
                                     input logic [4:0] rd);
        vec_t v;
        v.stim.inst    = inst_u'(inst);
        v.stim.pc      = pc;
        v.stim.rs1_val = rs1;
        v.stim.rs2_val = rs2;
        v.exp.kind     = kind;
        v.exp.value    = value;
        v.exp.next_pc  = next_pc;
        v.exp.rd       = rd;
        rows.push_back(v);
    endfunction

    `include "tb_vectors.svh"

    task automatic check_value(input int row, input word_t got, input word_t exp);
        if (got !== exp) begin
            $display("Mismatch row %0d out.value: got %h, expected %h", row, got, exp);
            errors++;
        end
    endtask

    task automatic check_pc(input int row, input addr_t got, input addr_t exp);
        if (got !== exp) begin
            $display("Mismatch row %0d out.next_pc: got %h, expected %h", row, got, exp);
            errors++;
        end
    endtask

    task automatic check_kind(input int row, input res_kind_e got, input res_kind_e exp);
        if (got !== exp) begin
            $display("Mismatch row %0d out.kind: got %h, expected %h", row, got, exp);
            errors++;
        end
    endtask

    task automatic check_rd(input int row, input logic [4:0] got, input logic [4:0] exp);
        if (got !== exp) begin
            $display("Mismatch row %0d out.rd: got %h, expected %h", row, got, exp);
            errors++;
        end
    endtask

    // Holds the row on the input until the pipe takes it.
    task automatic drive_row(input int idx);
        int waited;
        waited = 0;
        in_valid <= 1'b1;
        in_data  <= rows[idx].stim;
        do begin
            @(posedge clk);
            waited++;
        end while (!in_ready && waited < WAIT_LIMIT);
        if (in_ready) begin
            exp_q.push_back(idx);
        end else begin
            $display("Timed out waiting for in_ready on row %0d", idx);
            timed_out = 1'b1;
        end
    endtask

    task automatic measure_latency();
        int cycles;
        drive_row(0);
        in_valid <= 1'b0;
        if (!timed_out) begin
            cycles = 0;
            do begin
                @(posedge clk);
                cycles++;
            end while (!(out_valid && out_ready) && cycles < WAIT_LIMIT);
            if (!(out_valid && out_ready)) begin
                $display("Timed out waiting for the first result");
                timed_out = 1'b1;
            end else if (cycles != 3) begin
                $display("Latency check failed: %0d cycles instead of 3", cycles);
                errors++;
            end else begin
                $display("Latency check passed: %0d cycles", cycles);
            end
        end
    endtask

    task automatic drain();
        int waited;
        waited = 0;
        while (exp_q.size() != 0 && waited < WAIT_LIMIT) begin
            @(negedge clk);
            waited++;
        end
        if (exp_q.size() != 0) begin
            $display("Timed out with %0d results still outstanding", exp_q.size());
            timed_out = 1'b1;
        end
    endtask

    // The sink is ready about three cycles in four once the stream starts.
    always @(posedge clk) begin
        if (random_ready) begin
            out_ready <= ($random(seed) & 32'h3) != 0;
        end else begin
            out_ready <= 1'b1;
        end
    end

    always @(posedge clk) begin
        if (arst_n && out_valid && out_ready) begin
            if (exp_q.size() == 0) begin
                $display("A result arrived with no instruction in flight");
                errors++;
            end else begin
                cur         = exp_q.pop_front();
                errs_before = errors;
                check_kind(cur, out_data.kind, rows[cur].exp.kind);
                check_value(cur, out_data.value, rows[cur].exp.value);
                check_pc(cur, out_data.next_pc, rows[cur].exp.next_pc);
                check_rd(cur, out_data.rd, rows[cur].exp.rd);
                checked++;
                if (errors == errs_before) begin
                    $display("Row %0d passed", cur);
                end else begin
                    $display("Row %0d failed", cur);
                end
            end
        end
    end

    initial begin
        arst_n    = 1'b0;
        in_valid  = 1'b0;
        in_data   = '0;
        out_ready = 1'b1;
        fill_table();
        repeat (4) @(posedge clk);
        arst_n <= 1'b1;
        @(posedge clk);
        measure_latency();
        if (!timed_out) begin
            random_ready <= 1'b1;
            for (int i = 1; i < rows.size(); i++) begin
                if (!timed_out) begin
                    drive_row(i);
                end
            end
            in_valid <= 1'b0;
        end
        if (!timed_out) begin
            drain();
        end
        $display("Summary: %0d rows checked, %0d errors", checked, errors);
        if (timed_out || errors != 0) begin
            $display("TEST FAILED");
        end else begin
            $display("TEST OK");
        end
        $finish;
    end

endmodule

//--- vlog.f
+incdir+test
src/exec_pkg.sv
src/inst_decode.sv
src/alu.sv
src/exec_commit.sv
src/exec_pipe.sv
test/tb_exec_pipe.sv
